// ==== list.f ====
+incdir+common
common/mem_pkg.sv
common/apb_pkg.sv
mem_stage/mem_align.sv
mem_stage/mem_ctrl.sv
rtl/wait_timer.sv
rtl/apb_ram.sv
rtl/mem_unit_top.sv
testbench/mem_checker.sv
testbench/tb_mem_unit.sv

// ==== testbench/tb_mem_unit.sv ====
`include "mem_defines.svh"

module tb_mem_unit;
    import mem_pkg::*;

    localparam int REQ_LIMIT  = 20;
    localparam int RESP_LIMIT = `APB_TIMEOUT + 20;

    logic       clk;
    logic       rst_i;
    logic       req_valid_i;
    logic       req_ready_o;
    mem_req_t   req_i;
    logic       resp_valid_o;
    logic       resp_ready_i;
    mem_resp_t  resp_o;
    logic       timed_out;
    int         seed;
    int         rnd;

    mem_unit_top dut0 (
        .clk          (clk),
        .rst_i        (rst_i),
        .req_valid_i  (req_valid_i),
        .req_ready_o  (req_ready_o),
        .req_i        (req_i),
        .resp_valid_o (resp_valid_o),
        .resp_ready_i (resp_ready_i),
        .resp_o       (resp_o)
    );

    mem_checker chk0 (
        .clk          (clk),
        .rst_i        (rst_i),
        .req_valid_i  (req_valid_i),
        .req_ready_i  (req_ready_o),
        .req_i        (req_i),
        .resp_valid_i (resp_valid_o),
        .resp_ready_i (resp_ready_i),
        .resp_i       (resp_o)
    );

    always #5 clk = ~clk;

    function automatic logic [31:0] fill_word(input logic [31:0] addr);
        return (addr * 32'h9E37_79B9) ^ {addr[15:0], ~addr[15:0]} ^ 32'hC3A5_0F1E;
    endfunction

    function automatic logic [31:0] rand_word_addr();
        return ($urandom % `RAM_WORDS) * 4;
    endfunction

    // one request, then its response with a random stall
    task automatic do_req(input mem_op_e op, input logic [31:0] addr, input logic [31:0] wdata);
        int   n;
        int   stall;
        logic got;
        if (!timed_out) begin
            @(negedge clk);
            req_i.op    = op;
            req_i.addr  = addr;
            req_i.wdata = wdata;
            req_i.rd    = 5'($urandom % 32);
            req_i.we    = ($urandom % 4) != 0;
            req_valid_i = 1'b1;
            n   = 0;
            got = 1'b0;
            while (!got && n < REQ_LIMIT) begin
                @(posedge clk);
                got = req_ready_o;
                n++;
            end
            @(negedge clk);
            req_valid_i = 1'b0;
            if (!got) begin
                $display("Timeout: request at %h was not accepted", addr);
                timed_out = 1'b1;
            end else begin
                n   = 0;
                got = resp_valid_o;
                while (!got && n < RESP_LIMIT) begin
                    @(posedge clk);
                    got = resp_valid_o;
                    n++;
                end
                if (!got) begin
                    $display("Timeout: no response for request at %h", addr);
                    timed_out = 1'b1;
                end else begin
                    stall = $urandom % 3;
                    @(negedge clk);
                    // offered while the response is held, must not be taken
                    req_valid_i = (stall != 0);
                    repeat (stall) @(negedge clk);
                    req_valid_i  = 1'b0;
                    resp_ready_i = 1'b1;
                    @(negedge clk);
                    resp_ready_i = 1'b0;
                end
            end
        end
    endtask

    task automatic test_lanes();
        int          n;
        int          k;
        logic [31:0] base;
        for (n = 0; n < 12; n++) begin
            base = rand_word_addr();
            case (n % 3)
                0: do_req(ST_B, base + ($urandom % 4), $urandom);
                1: do_req(ST_H, base + 2 * ($urandom % 2), $urandom);
                default: do_req(ST_W, base, $urandom);
            endcase
            for (k = 0; k < 4; k++) begin
                do_req(LD_B, base + k, 32'd0);
                do_req(LD_BU, base + k, 32'd0);
            end
            for (k = 0; k < 4; k += 2) begin
                do_req(LD_H, base + k, 32'd0);
                do_req(LD_HU, base + k, 32'd0);
            end
            do_req(LD_W, base, 32'd0);
        end
    endtask

    task automatic test_misaligned();
        int          n;
        logic [31:0] base;
        logic [31:0] odd;
        logic [31:0] off;
        for (n = 0; n < 16; n++) begin
            base = rand_word_addr();
            odd  = 1 + 2 * ($urandom % 2);
            off  = 1 + ($urandom % 3);
            case ($urandom % 7)
                0: do_req(LD_H, base + odd, 32'd0);
                1: do_req(LD_HU, base + odd, 32'd0);
                2: do_req(ST_H, base + odd, $urandom);
                3: do_req(LD_W, base + off, 32'd0);
                4: do_req(ST_W, base + off, $urandom);
                5: do_req(LL, base + off, 32'd0);
                default: do_req(SC, base + off, $urandom);
            endcase
            do_req(LD_W, base, 32'd0);
        end
    endtask

    task automatic test_ll_sc();
        int          n;
        logic [31:0] base;
        for (n = 0; n < 4; n++) begin
            base = rand_word_addr();
            do_req(LL, base, 32'd0);
            do_req(SC, base, $urandom);
            do_req(LD_W, base, 32'd0);
            do_req(SC, base, $urandom);
            do_req(LD_W, base, 32'd0);
            do_req(SC, (base + 4) % (`RAM_WORDS * 4), $urandom);
        end
    endtask

    task automatic test_unmapped();
        int          n;
        logic [31:0] addr;
        for (n = 0; n < 6; n++) begin
            addr = (($urandom % 1024) + `RAM_WORDS) * 4;
            case (n % 5)
                0: do_req(LD_W, addr, 32'd0);
                1: do_req(ST_W, addr, $urandom);
                2: do_req(LD_B, addr, 32'd0);
                3: do_req(ST_B, addr, $urandom);
                default: do_req(LL, addr, 32'd0);
            endcase
            do_req(LD_W, rand_word_addr(), 32'd0);
        end
    endtask

    task automatic test_random();
        int          n;
        logic [31:0] addr;
        for (n = 0; n < 200; n++) begin
            if ($urandom % 8 == 0) begin
                addr = ($urandom % 1024 + `RAM_WORDS) * 4 + $urandom % 4;
            end else begin
                addr = $urandom % (`RAM_WORDS * 4);
            end
            do_req(mem_op_e'($urandom % 11), addr, $urandom);
        end
    endtask

    initial begin
        clk          = 1'b0;
        rst_i        = 1'b1;
        req_valid_i  = 1'b0;
        req_i        = '0;
        resp_ready_i = 1'b0;
        timed_out    = 1'b0;
        seed         = 44;
        rnd          = $urandom(seed);
        repeat (16) @(posedge clk);
        @(negedge clk);
        rst_i = 1'b0;
        @(negedge clk);

        chk0.begin_test("reset_state");
        chk0.check_idle();
        do_req(SC, 32'h0, 32'hDEAD_BEEF);
        chk0.end_test();

        chk0.begin_test("fill_pattern");
        for (int i = 0; i < `RAM_WORDS; i++) begin
            do_req(ST_W, i * 4, fill_word(i * 4));
        end
        chk0.end_test();

        chk0.begin_test("store_load_lanes");
        test_lanes();
        chk0.end_test();
        chk0.begin_test("misaligned");
        test_misaligned();
        chk0.end_test();
        chk0.begin_test("ll_sc");
        test_ll_sc();
        chk0.end_test();
        chk0.begin_test("unmapped");
        test_unmapped();
        chk0.end_test();
        chk0.begin_test("random_mix");
        test_random();
        chk0.end_test();

        repeat (4) @(negedge clk);
        $display("tests %0d, failed tests %0d, responses %0d, errors %0d",
                 chk0.test_cnt, chk0.fail_cnt, chk0.resp_cnt, chk0.err_cnt);
        if (timed_out || chk0.err_cnt != 0) begin
            $display("Verification failed");
        end else begin
            $display("Verification passed");
        end
        $finish;
    end

endmodule

// ==== testbench/mem_checker.sv ====
`include "mem_defines.svh"

module mem_checker (
    input logic                clk,
    input logic                rst_i,
    input logic                req_valid_i,
    input logic                req_ready_i,
    input mem_pkg::mem_req_t   req_i,
    input logic                resp_valid_i,
    input logic                resp_ready_i,
    input mem_pkg::mem_resp_t  resp_i
);
    import mem_pkg::*;

    // edges from the accepting edge to the first edge that samples resp_valid_o
    localparam int SKIP_LAT  = 1;
    localparam int BUS_LAT   = 3 + `RAM_WAIT;
    localparam int ABORT_LAT = 2 + `APB_TIMEOUT;

    logic [`DATA_W-1:0]  model_mem [`RAM_WORDS];
    logic                model_ll;
    mem_resp_t           exp_resp;
    mem_resp_t           held_resp;
    int                  exp_lat;
    logic                pending;
    logic                seen;
    logic                stalled;
    int                  cyc;
    int                  acc_cyc;
    string               test_name = "none";
    int                  err_cnt = 0;
    int                  test_cnt = 0;
    int                  fail_cnt = 0;
    int                  resp_cnt = 0;
    int                  test_err = 0;
    int                  test_resp = 0;

    task automatic report_value(input string what, input logic [63:0] exp,
                                input logic [63:0] act);
        if (exp !== act) begin
            $display("Error %s: %s expected %h actual %h", test_name, what, exp, act);
            err_cnt++;
        end
    endtask

    task automatic report_fault(input string what);
        $display("Failure in %s: %s", test_name, what);
        err_cnt++;
    endtask

    task automatic begin_test(input string name);
        test_name = name;
        test_err  = err_cnt;
        test_resp = resp_cnt;
    endtask

    task automatic end_test();
        test_cnt++;
        if (err_cnt != test_err) begin
            fail_cnt++;
        end
        $display("test %-16s %0d responses, %0d errors", test_name,
                 resp_cnt - test_resp, err_cnt - test_err);
    endtask

    task automatic check_idle();
        report_value("resp_valid_o", 64'd0, resp_valid_i);
        report_value("req_ready_o", 64'd1, req_ready_i);
    endtask

    // model: byte k of a word lives in bits 31-8k down
    task automatic apply_req(input mem_req_t r);
        logic [1:0]          ofs;
        logic [`ADDR_W-3:0]  idx;
        logic                mapped;
        logic                bus;
        logic                wr;
        logic [31:0]         word;
        logic [31:0]         wval;
        logic [7:0]          b;
        logic [15:0]         h;
        ofs    = r.addr[1:0];
        idx    = r.addr[`ADDR_W-1:2];
        mapped = (idx < `RAM_WORDS);
        word   = mapped ? model_mem[idx] : '0;
        b      = word[31 - 8 * ofs -: 8];
        h      = ofs[1] ? word[15:0] : word[31:16];
        wval   = word;
        bus    = 1'b0;
        wr     = 1'b0;
        exp_resp      = '0;
        exp_resp.rd   = r.rd;
        exp_resp.excp = NONE;
        case (r.op)
            LD_B, LD_BU: begin
                bus = 1'b1;
                exp_resp.we    = r.we;
                exp_resp.wdata = (r.op == LD_B) ? {{24{b[7]}}, b} : {24'b0, b};
            end
            LD_H, LD_HU: begin
                if (ofs[0]) begin
                    exp_resp.excp = ALE;
                end else begin
                    bus = 1'b1;
                    exp_resp.we    = r.we;
                    exp_resp.wdata = (r.op == LD_H) ? {{16{h[15]}}, h} : {16'b0, h};
                end
            end
            LD_W: begin
                if (ofs != 2'd0) begin
                    exp_resp.excp = ALE;
                end else begin
                    bus = 1'b1;
                    exp_resp.we    = r.we;
                    exp_resp.wdata = word;
                end
            end
            LL: begin
                if (ofs != 2'd0) begin
                    exp_resp.excp = ALE;
                end else begin
                    bus = 1'b1;
                    exp_resp.wdata = word;
                    model_ll = 1'b1;
                end
            end
            ST_B: begin
                bus = 1'b1;
                wr  = 1'b1;
                wval[31 - 8 * ofs -: 8] = r.wdata[7:0];
            end
            ST_H: begin
                if (ofs[0]) begin
                    exp_resp.excp = ALE;
                end else begin
                    bus = 1'b1;
                    wr  = 1'b1;
                    if (ofs[1]) begin
                        wval[15:0] = r.wdata[15:0];
                    end else begin
                        wval[31:16] = r.wdata[15:0];
                    end
                end
            end
            ST_W: begin
                if (ofs != 2'd0) begin
                    exp_resp.excp = ALE;
                end else begin
                    bus  = 1'b1;
                    wr   = 1'b1;
                    wval = r.wdata;
                end
            end
            SC: begin
                if (ofs != 2'd0) begin
                    exp_resp.excp = ALE;
                end else if (model_ll) begin
                    bus  = 1'b1;
                    wr   = 1'b1;
                    wval = r.wdata;
                    exp_resp.we    = r.we;
                    exp_resp.wdata = 32'd1;
                    model_ll = 1'b0;
                end else begin
                    exp_resp.we    = r.we;
                    exp_resp.wdata = 32'd0;
                end
            end
            default: begin
            end
        endcase
        exp_lat = SKIP_LAT;
        if (bus && mapped) begin
            exp_lat = BUS_LAT;
            if (wr) begin
                model_mem[idx] = wval;
            end
        end else if (bus) begin
            // slave never answers, the timer aborts
            exp_lat        = ABORT_LAT;
            exp_resp.we    = 1'b0;
            exp_resp.wdata = '0;
            exp_resp.excp  = BUSERR;
        end
    endtask

    always @(posedge clk) begin
        if (rst_i) begin
            cyc      = 0;
            pending  = 1'b0;
            seen     = 1'b0;
            stalled  = 1'b0;
            model_ll = 1'b0;
        end else begin
            cyc++;
            if (req_valid_i && req_ready_i) begin
                if (pending) begin
                    report_fault("request accepted while another was in flight");
                end
                apply_req(req_i);
                acc_cyc = cyc;
                pending = 1'b1;
                seen    = 1'b0;
            end
            if (resp_valid_i) begin
                if (req_ready_i) begin
                    report_fault("request port ready while a response is held");
                end
                if (!pending) begin
                    report_fault("response with no request outstanding");
                end else if (!seen) begin
                    report_value("latency", exp_lat, cyc - acc_cyc);
                    report_value("resp.we", exp_resp.we, resp_i.we);
                    report_value("resp.rd", exp_resp.rd, resp_i.rd);
                    report_value("resp.wdata", exp_resp.wdata, resp_i.wdata);
                    report_value("resp.excp", exp_resp.excp, resp_i.excp);
                    seen = 1'b1;
                end else if (stalled) begin
                    report_value("held response", held_resp, resp_i);
                end
                held_resp = resp_i;
                stalled   = !resp_ready_i;
                if (resp_ready_i) begin
                    pending = 1'b0;
                    seen    = 1'b0;
                    resp_cnt++;
                end
            end
        end
    end

endmodule

// ==== rtl/mem_unit_top.sv ====
`include "mem_defines.svh"

module mem_unit_top (
    input  logic                clk,
    input  logic                rst_i,
    input  logic                req_valid_i,
    output logic                req_ready_o,
    input  mem_pkg::mem_req_t   req_i,
    output logic                resp_valid_o,
    input  logic                resp_ready_i,
    output mem_pkg::mem_resp_t  resp_o
);
    import mem_pkg::*;
    import apb_pkg::*;

    mem_req_t            cur_req;
    mem_resp_t           fmt_resp;
    mem_excp_e           excp;
    apb_req_t            apb_req;
    apb_rsp_t            apb_rsp;
    logic                need_bus;
    logic                bus_write;
    logic [`STRB_W-1:0]  bus_strb;
    logic [`DATA_W-1:0]  bus_wdata;
    logic [`DATA_W-1:0]  rdata;
    logic                commit;
    logic                tmr_run;
    logic                tmr_expired;

    mem_ctrl u_ctrl (
        .clk           (clk),
        .rst_i         (rst_i),
        .req_valid_i   (req_valid_i),
        .req_ready_o   (req_ready_o),
        .req_i         (req_i),
        .resp_valid_o  (resp_valid_o),
        .resp_ready_i  (resp_ready_i),
        .resp_o        (resp_o),
        .cur_req_o     (cur_req),
        .need_bus_i    (need_bus),
        .bus_write_i   (bus_write),
        .bus_strb_i    (bus_strb),
        .bus_wdata_i   (bus_wdata),
        .excp_i        (excp),
        .fmt_resp_i    (fmt_resp),
        .rdata_o       (rdata),
        .commit_o      (commit),
        .apb_o         (apb_req),
        .apb_i         (apb_rsp),
        .tmr_run_o     (tmr_run),
        .tmr_expired_i (tmr_expired)
    );

    wait_timer u_timer (
        .clk       (clk),
        .rst_i     (rst_i),
        .run_i     (tmr_run),
        .expired_o (tmr_expired)
    );

    mem_align u_align (
        .clk         (clk),
        .rst_i       (rst_i),
        .req_i       (cur_req),
        .rdata_i     (rdata),
        .commit_i    (commit),
        .need_bus_o  (need_bus),
        .bus_write_o (bus_write),
        .bus_strb_o  (bus_strb),
        .bus_wdata_o (bus_wdata),
        .excp_o      (excp),
        .resp_o      (fmt_resp)
    );

    apb_ram u_ram (
        .clk   (clk),
        .rst_i (rst_i),
        .apb_i (apb_req),
        .apb_o (apb_rsp)
    );

endmodule

// ==== rtl/apb_ram.sv ====
`include "mem_defines.svh"

module apb_ram (
    input  logic               clk,
    input  logic               rst_i,
    input  apb_pkg::apb_req_t  apb_i,
    output apb_pkg::apb_rsp_t  apb_o
);
    localparam int IDX_W  = $clog2(`RAM_WORDS);
    localparam int WAIT_W = $clog2(`RAM_WAIT + 1) + 1;

    logic [`DATA_W-1:0]  mem_q [`RAM_WORDS];
    logic [`ADDR_W-3:0]  word_idx;
    logic                mapped;
    logic                access;
    logic [WAIT_W-1:0]   wait_q;
    logic                pready_q;
    logic [`DATA_W-1:0]  prdata_q;

    assign word_idx = apb_i.paddr[`ADDR_W-1:2];
    assign mapped   = (word_idx < `RAM_WORDS);
    // unmapped words never see an access
    assign access   = apb_i.psel && apb_i.penable && mapped;

    // pready is registered, so it is raised at the end of the last wait cycle
    always_ff @(posedge clk) begin
        if (rst_i || !access || pready_q) begin
            wait_q   <= '0;
            pready_q <= 1'b0;
        end else if (wait_q == WAIT_W'(`RAM_WAIT - 1)) begin
            pready_q <= 1'b1;
        end else begin
            wait_q <= wait_q + 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (access && !pready_q) begin
            prdata_q <= mem_q[word_idx[IDX_W-1:0]];
        end
        if (access && pready_q && apb_i.pwrite) begin
            for (int i = 0; i < `STRB_W; i++) begin
                if (apb_i.pstrb[i]) begin
                    mem_q[word_idx[IDX_W-1:0]][8*i +: 8] <= apb_i.pwdata[8*i +: 8];
                end
            end
        end
    end

    assign apb_o.pready = pready_q;
    assign apb_o.prdata = prdata_q;

endmodule

// ==== rtl/wait_timer.sv ====
`include "mem_defines.svh"

module wait_timer (
    input  logic clk,
    input  logic rst_i,
    input  logic run_i,
    output logic expired_o
);
    localparam int CNT_W = $clog2(`APB_TIMEOUT);

    logic [CNT_W-1:0] cnt_q;

    // counts finished access cycles, saturates until run drops
    always_ff @(posedge clk) begin
        if (rst_i || !run_i) begin
            cnt_q <= '0;
        end else if (cnt_q != CNT_W'(`APB_TIMEOUT - 1)) begin
            cnt_q <= cnt_q + 1'b1;
        end
    end

    // the current access cycle is the last one allowed
    assign expired_o = (cnt_q == CNT_W'(`APB_TIMEOUT - 1));

    assert property (@(posedge clk) disable iff (rst_i)
        $rose(expired_o) |-> $past(run_i));

endmodule

// ==== mem_stage/mem_ctrl.sv ====
`include "mem_defines.svh"

module mem_ctrl (
    input  logic                 clk,
    input  logic                 rst_i,
    input  logic                 req_valid_i,
    output logic                 req_ready_o,
    input  mem_pkg::mem_req_t    req_i,
    output logic                 resp_valid_o,
    input  logic                 resp_ready_i,
    output mem_pkg::mem_resp_t   resp_o,
    output mem_pkg::mem_req_t    cur_req_o,
    input  logic                 need_bus_i,
    input  logic                 bus_write_i,
    input  logic [`STRB_W-1:0]   bus_strb_i,
    input  logic [`DATA_W-1:0]   bus_wdata_i,
    input  mem_pkg::mem_excp_e   excp_i,
    input  mem_pkg::mem_resp_t   fmt_resp_i,
    output logic [`DATA_W-1:0]   rdata_o,
    output logic                 commit_o,
    output apb_pkg::apb_req_t    apb_o,
    input  apb_pkg::apb_rsp_t    apb_i,
    output logic                 tmr_run_o,
    input  logic                 tmr_expired_i
);
    import mem_pkg::*;
    import apb_pkg::*;

    ctrl_state_e  state_q;
    ctrl_state_e  state_d;
    mem_req_t     req_q;
    mem_resp_t    resp_q;
    mem_resp_t    resp_d;
    logic         ready_q;
    logic         accept;
    logic         xfer_done;
    logic         timed_out;

    assign accept    = req_valid_i && ready_q;
    assign xfer_done = (state_q == ACCESS) && (apb_i.pready || tmr_expired_i);
    assign timed_out = (state_q == ACCESS) && !apb_i.pready && tmr_expired_i;

    // the incoming request is decoded while still in IDLE
    assign cur_req_o = (state_q == IDLE) ? req_i : req_q;
    assign commit_o  = (accept && !need_bus_i) || xfer_done;

    always_comb begin
        state_d = state_q;
        case (state_q)
            IDLE: begin
                if (accept) begin
                    state_d = need_bus_i ? SETUP : DONE;
                end
            end
            SETUP: begin
                state_d = ACCESS;
            end
            ACCESS: begin
                if (xfer_done) begin
                    state_d = DONE;
                end
            end
            DONE: begin
                if (resp_ready_i) begin
                    state_d = IDLE;
                end
            end
        endcase
    end

    always_comb begin
        resp_d      = fmt_resp_i;
        resp_d.excp = excp_i;
        if (timed_out) begin
            resp_d.excp  = BUSERR;
            resp_d.we    = 1'b0;
            resp_d.wdata = '0;
        end
    end

    always_ff @(posedge clk) begin
        if (rst_i) begin
            state_q <= IDLE;
            ready_q <= 1'b0;
        end else begin
            state_q <= state_d;
            ready_q <= (state_d == IDLE);
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            req_q <= req_i;
        end
        if (commit_o) begin
            resp_q <= resp_d;
        end
    end

    assign apb_o.psel    = (state_q == SETUP) || (state_q == ACCESS);
    assign apb_o.penable = (state_q == ACCESS);
    assign apb_o.pwrite  = bus_write_i;
    assign apb_o.paddr   = req_q.addr;
    assign apb_o.pwdata  = bus_wdata_i;
    assign apb_o.pstrb   = bus_strb_i;

    assign rdata_o      = (state_q == ACCESS) ? apb_i.prdata : '0;
    assign tmr_run_o    = (state_q == ACCESS);
    assign req_ready_o  = ready_q;
    assign resp_valid_o = (state_q == DONE);
    assign resp_o       = resp_q;

    // access phase always follows a one-cycle setup phase
    assert property (@(posedge clk) disable iff (rst_i)
        $rose(apb_o.penable) |-> apb_o.psel && $past(apb_o.psel && !apb_o.penable));

    assert property (@(posedge clk) disable iff (rst_i)
        resp_valid_o && !resp_ready_i |=> resp_valid_o && $stable(resp_o));

endmodule

// ==== mem_stage/mem_align.sv ====
`include "mem_defines.svh"

module mem_align (
    input  logic                 clk,
    input  logic                 rst_i,
    input  mem_pkg::mem_req_t    req_i,
    input  logic [`DATA_W-1:0]   rdata_i,
    input  logic                 commit_i,
    output logic                 need_bus_o,
    output logic                 bus_write_o,
    output logic [`STRB_W-1:0]   bus_strb_o,
    output logic [`DATA_W-1:0]   bus_wdata_o,
    output mem_pkg::mem_excp_e   excp_o,
    output mem_pkg::mem_resp_t   resp_o
);
    import mem_pkg::*;

    logic [1:0]          ofs;
    logic [`STRB_W-1:0]  byte_strb;
    logic [`STRB_W-1:0]  half_strb;
    logic [7:0]          rd_byte;
    logic [15:0]         rd_half;
    logic                half_mis;
    logic                word_mis;
    logic                ll_q;

    // byte 0 sits in the most significant lane
    assign ofs       = req_i.addr[1:0];
    assign byte_strb = 4'b1000 >> ofs;
    assign half_strb = ofs[1] ? 4'b0011 : 4'b1100;
    assign rd_byte   = rdata_i[8 * (3 - ofs) +: 8];
    assign rd_half   = ofs[1] ? rdata_i[15:0] : rdata_i[31:16];
    assign half_mis  = ofs[0];
    assign word_mis  = (ofs != 2'b00);

    always_comb begin
        need_bus_o   = 1'b0;
        bus_write_o  = 1'b0;
        bus_strb_o   = '0;
        bus_wdata_o  = '0;
        excp_o       = NONE;
        resp_o.we    = 1'b0;
        resp_o.rd    = req_i.rd;
        resp_o.wdata = '0;
        case (req_i.op)
            LD_B, LD_BU: begin
                need_bus_o   = 1'b1;
                bus_strb_o   = byte_strb;
                resp_o.we    = req_i.we;
                resp_o.wdata = (req_i.op == LD_B) ? {{24{rd_byte[7]}}, rd_byte}
                                                  : {24'b0, rd_byte};
            end
            LD_H, LD_HU: begin
                if (half_mis) begin
                    excp_o = ALE;
                end else begin
                    need_bus_o   = 1'b1;
                    bus_strb_o   = half_strb;
                    resp_o.we    = req_i.we;
                    resp_o.wdata = (req_i.op == LD_H) ? {{16{rd_half[15]}}, rd_half}
                                                      : {16'b0, rd_half};
                end
            end
            LD_W, LL: begin
                if (word_mis) begin
                    excp_o = ALE;
                end else begin
                    need_bus_o   = 1'b1;
                    bus_strb_o   = '1;
                    // LL only reserves, the register is left alone
                    resp_o.we    = req_i.we && (req_i.op == LD_W);
                    resp_o.wdata = rdata_i;
                end
            end
            ST_B: begin
                need_bus_o  = 1'b1;
                bus_write_o = 1'b1;
                bus_strb_o  = byte_strb;
                bus_wdata_o = {4{req_i.wdata[7:0]}};
            end
            ST_H: begin
                if (half_mis) begin
                    excp_o = ALE;
                end else begin
                    need_bus_o  = 1'b1;
                    bus_write_o = 1'b1;
                    bus_strb_o  = half_strb;
                    bus_wdata_o = {2{req_i.wdata[15:0]}};
                end
            end
            ST_W: begin
                if (word_mis) begin
                    excp_o = ALE;
                end else begin
                    need_bus_o  = 1'b1;
                    bus_write_o = 1'b1;
                    bus_strb_o  = '1;
                    bus_wdata_o = req_i.wdata;
                end
            end
            SC: begin
                if (word_mis) begin
                    excp_o = ALE;
                end else if (ll_q) begin
                    need_bus_o   = 1'b1;
                    bus_write_o  = 1'b1;
                    bus_strb_o   = '1;
                    bus_wdata_o  = req_i.wdata;
                    resp_o.we    = req_i.we;
                    resp_o.wdata = 32'd1;
                end else begin
                    // lost reservation, no bus access
                    resp_o.we    = req_i.we;
                    resp_o.wdata = 32'd0;
                end
            end
            default: begin
            end
        endcase
        resp_o.excp = excp_o;
    end

    // LL bit, only touched on commit
    always_ff @(posedge clk) begin
        if (rst_i) begin
            ll_q <= 1'b0;
        end else if (commit_i && excp_o == NONE) begin
            if (req_i.op == LL) begin
                ll_q <= 1'b1;
            end else if (req_i.op == SC && need_bus_o) begin
                ll_q <= 1'b0;
            end
        end
    end

endmodule

// ==== common/apb_pkg.sv ====
`include "mem_defines.svh"

package apb_pkg;

    typedef struct packed {
        logic                psel;
        logic                penable;
        logic                pwrite;
        logic [`ADDR_W-1:0]  paddr;
        logic [`DATA_W-1:0]  pwdata;
        logic [`STRB_W-1:0]  pstrb;
    } apb_req_t;

    typedef struct packed {
        logic                pready;
        logic [`DATA_W-1:0]  prdata;
    } apb_rsp_t;

    // one APB transfer per request
    typedef enum logic [1:0] {
        IDLE,
        SETUP,
        ACCESS,
        DONE
    } ctrl_state_e;

endpackage

// ==== common/mem_pkg.sv ====
`include "mem_defines.svh"

package mem_pkg;

    typedef enum logic [3:0] {
        LD_B,
        LD_BU,
        LD_H,
        LD_HU,
        LD_W,
        ST_B,
        ST_H,
        ST_W,
        LL,
        SC,
        NOP
    } mem_op_e;

    // ALE for misaligned half/word, BUSERR for a bus timeout
    typedef enum logic [1:0] {
        NONE,
        ALE,
        BUSERR
    } mem_excp_e;

    typedef struct packed {
        mem_op_e             op;
        logic [`ADDR_W-1:0]  addr;
        logic [`DATA_W-1:0]  wdata;
        logic [4:0]          rd;
        logic                we;
    } mem_req_t;

    typedef struct packed {
        logic                we;
        logic [4:0]          rd;
        logic [`DATA_W-1:0]  wdata;
        mem_excp_e           excp;
    } mem_resp_t;

endpackage

// ==== common/mem_defines.svh ====
`ifndef MEM_DEFINES_SVH
`define MEM_DEFINES_SVH

// bus widths
`define DATA_W 32
`define ADDR_W 32
`define STRB_W (`DATA_W / 8)

// mapped words, indexes at or above are unmapped
`define RAM_WORDS 64

// access cycles counted by the RAM before PREADY
`define RAM_WAIT 2

// access cycles before abort, keep well above RAM_WAIT
`define APB_TIMEOUT 8

`endif
